// File: source/opl3_reg_map_pkg.sv
// bus widths, address map constants, register group enum, bus request struct
`default_nettype none

package opl3_reg_map_pkg;

    localparam int NUM_BANKS     = 2;
    localparam int NUM_OPERATORS = 18;  // per bank
    localparam int NUM_CHANNELS  = 9;   // per bank

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 8;

    // high address nibble of each kept group
    localparam logic [3:0] GROUP_BASE_OP_CHAR    = 4'h2;
    localparam logic [3:0] GROUP_BASE_OP_LEVEL   = 4'h4;
    localparam logic [3:0] GROUP_BASE_OP_ENV     = 4'h6;
    localparam logic [3:0] GROUP_BASE_OP_SUSTAIN = 4'h8;
    localparam logic [3:0] GROUP_BASE_OP_WAVE    = 4'hE;
    localparam logic [3:0] GROUP_BASE_CH_FNUM_LO = 4'hA;
    localparam logic [3:0] GROUP_BASE_CH_KEY     = 4'hB;
    localparam logic [3:0] GROUP_BASE_CH_OUT     = 4'hC;

    localparam logic [DATA_WIDTH-1:0] READ_UNMAPPED = 8'hFF;

    typedef enum logic [3:0] {
        GRP_NONE       = 4'd0,
        GRP_OP_CHAR    = 4'd1,
        GRP_OP_LEVEL   = 4'd2,
        GRP_OP_ENV     = 4'd3,
        GRP_OP_SUSTAIN = 4'd4,
        GRP_OP_WAVE    = 4'd5,
        GRP_CH_FNUM_LO = 4'd6,
        GRP_CH_KEY     = 4'd7,
        GRP_CH_OUT     = 4'd8
    } reg_group_e;

    typedef logic [4:0] op_index_t;
    typedef logic [3:0] ch_index_t;

    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic                  bank;
        reg_group_e            group;
        op_index_t             index;  // operator or channel
        logic [DATA_WIDTH-1:0] data;
        logic [3:0]            pad;
    } bus_req_t;

endpackage

`default_nettype wire

// File: source/opl3_voice_pkg.sv
// operator and channel parameter structs, bank arrays, register byte union
`default_nettype none

package opl3_voice_pkg;

    import opl3_reg_map_pkg::*;

    // 35 parameter bits plus one pad, nine hex digits
    typedef struct packed {
        logic       pad;
        logic       am;    // tremolo
        logic       vib;   // vibrato
        logic       egt;   // sustained envelope
        logic       ksr;
        logic [3:0] mult;
        logic [1:0] ksl;
        logic [5:0] tl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
        logic [2:0] ws;
    } op_params_t;

    // 22 bits
    typedef struct packed {
        logic [9:0] fnum;
        logic [2:0] block;
        logic       kon;
        logic       cha;
        logic       chb;
        logic       chc;
        logic       chd;
        logic [2:0] fb;
        logic       cnt;
    } ch_params_t;

    typedef op_params_t [NUM_BANKS-1:0][NUM_OPERATORS-1:0] op_bank_t;
    typedef ch_params_t [NUM_BANKS-1:0][NUM_CHANNELS-1:0]  ch_bank_t;

    // one register byte, decoded per group layout
    typedef union packed {
        struct packed {
            logic       am;
            logic       vib;
            logic       egt;
            logic       ksr;
            logic [3:0] mult;
        } op_char;
        struct packed {
            logic [1:0] ksl;
            logic [5:0] tl;
        } op_level;
        struct packed {
            logic [3:0] hi;  // ar or sl
            logic [3:0] lo;  // dr or rr
        } op_rate;
        struct packed {
            logic [4:0] zero;
            logic [2:0] ws;
        } op_wave;
        struct packed {
            logic [1:0] zero;
            logic       kon;
            logic [2:0] block;
            logic [1:0] fnum_hi;
        } ch_key;
        struct packed {
            logic       chd;
            logic       chc;
            logic       chb;
            logic       cha;
            logic [2:0] fb;
            logic       cnt;
        } ch_out;
        logic [DATA_WIDTH-1:0] raw;
    } reg_byte_u;

endpackage

`default_nettype wire

// File: source/opl3_bus_decoder.sv
// bus strobe register and address/bank decode into a bus request
`timescale 1ns/10ps
`default_nettype none

module opl3_bus_decoder
    import opl3_reg_map_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cs,
    input  wire                  rd,
    input  wire                  wr,
    input  wire                  bank_select,
    input  wire [ADDR_WIDTH-1:0] address,
    input  wire [DATA_WIDTH-1:0] data_in,
    output bus_req_t             req
);

    bus_req_t   req_next;
    reg_group_e grp;
    logic [4:0] op_off;
    logic       op_hit;
    logic       ch_hit;
    op_index_t  op_idx;

    assign op_off = address[4:0];  // operator groups span two nibbles
    assign op_hit = (op_off[2:0] < 3'd6) && (op_off[4:3] != 2'b11);
    assign ch_hit = ({1'b0, address[3:0]} < 5'(NUM_CHANNELS));
    assign op_idx = op_off - 5'({op_off[4:3], 1'b0});  // close the 6-7, 14-15 gaps

    always_comb begin
        grp = GRP_NONE;
        if (op_hit) begin
            case (address[7:5])
                GROUP_BASE_OP_CHAR[3:1]:    grp = GRP_OP_CHAR;
                GROUP_BASE_OP_LEVEL[3:1]:   grp = GRP_OP_LEVEL;
                GROUP_BASE_OP_ENV[3:1]:     grp = GRP_OP_ENV;
                GROUP_BASE_OP_SUSTAIN[3:1]: grp = GRP_OP_SUSTAIN;
                GROUP_BASE_OP_WAVE[3:1]:    grp = GRP_OP_WAVE;
                default:                    grp = GRP_NONE;
            endcase
        end
        if (grp == GRP_NONE && ch_hit) begin
            case (address[7:4])
                GROUP_BASE_CH_FNUM_LO: grp = GRP_CH_FNUM_LO;
                GROUP_BASE_CH_KEY:     grp = GRP_CH_KEY;
                GROUP_BASE_CH_OUT:     grp = GRP_CH_OUT;
                default:               grp = GRP_NONE;
            endcase
        end
    end

    always_comb begin
        req_next       = '0;
        req_next.wr    = cs && wr && (grp != GRP_NONE);  // unmapped writes dropped
        req_next.rd    = cs && rd;                       // unmapped reads still answered
        req_next.bank  = bank_select;
        req_next.group = grp;
        req_next.data  = data_in;
        case (grp)
            GRP_CH_FNUM_LO, GRP_CH_KEY, GRP_CH_OUT: req_next.index = {1'b0, address[3:0]};
            GRP_NONE: req_next.index = '0;
            default:  req_next.index = op_idx;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= '0;
        end else begin
            req <= req_next;
        end
    end

    // host never strobes both directions at once
    assert property (@(posedge clk) disable iff (!rst_n) cs |-> !(rd && wr));

endmodule

`default_nettype wire

// File: source/opl3_operator_regs.sv
// operator parameter storage for both banks
`timescale 1ns/10ps
`default_nettype none

module opl3_operator_regs
    import opl3_reg_map_pkg::*;
    import opl3_voice_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire bus_req_t req,
    output op_bank_t      op_params
);

    reg_byte_u wr_byte;
    op_index_t op_idx;
    logic      op_write;

    assign wr_byte  = req.data;
    assign op_idx   = req.index;
    assign op_write = req.wr && (req.group inside {GRP_OP_CHAR, GRP_OP_LEVEL, GRP_OP_ENV,
                                                   GRP_OP_SUSTAIN, GRP_OP_WAVE});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_params <= '0;
        end else if (op_write) begin
            case (req.group)
                GRP_OP_CHAR: begin
                    op_params[req.bank][op_idx].am   <= wr_byte.op_char.am;
                    op_params[req.bank][op_idx].vib  <= wr_byte.op_char.vib;
                    op_params[req.bank][op_idx].egt  <= wr_byte.op_char.egt;
                    op_params[req.bank][op_idx].ksr  <= wr_byte.op_char.ksr;
                    op_params[req.bank][op_idx].mult <= wr_byte.op_char.mult;
                end
                GRP_OP_LEVEL: begin
                    op_params[req.bank][op_idx].ksl <= wr_byte.op_level.ksl;
                    op_params[req.bank][op_idx].tl  <= wr_byte.op_level.tl;
                end
                GRP_OP_ENV: begin
                    op_params[req.bank][op_idx].ar <= wr_byte.op_rate.hi;
                    op_params[req.bank][op_idx].dr <= wr_byte.op_rate.lo;
                end
                GRP_OP_SUSTAIN: begin
                    op_params[req.bank][op_idx].sl <= wr_byte.op_rate.hi;
                    op_params[req.bank][op_idx].rr <= wr_byte.op_rate.lo;
                end
                GRP_OP_WAVE: op_params[req.bank][op_idx].ws <= wr_byte.op_wave.ws;
                default: ;
            endcase
        end
    end

    // decoder slot mapping must land inside the operator array
    assert property (@(posedge clk) disable iff (!rst_n)
        op_write |-> (op_idx < NUM_OPERATORS));

endmodule

`default_nettype wire

// File: source/opl3_channel_regs.sv
// channel parameter storage for both banks
`timescale 1ns/10ps
`default_nettype none

module opl3_channel_regs
    import opl3_reg_map_pkg::*;
    import opl3_voice_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire bus_req_t req,
    output ch_bank_t      ch_params
);

    reg_byte_u wr_byte;
    ch_index_t ch_idx;
    logic      ch_write;

    assign wr_byte  = req.data;
    assign ch_idx   = req.index[3:0];
    assign ch_write = req.wr && (req.group inside {GRP_CH_FNUM_LO, GRP_CH_KEY, GRP_CH_OUT});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_params <= '0;
        end else if (ch_write) begin
            case (req.group)
                GRP_CH_FNUM_LO: ch_params[req.bank][ch_idx].fnum[7:0] <= wr_byte.raw;
                GRP_CH_KEY: begin
                    ch_params[req.bank][ch_idx].kon       <= wr_byte.ch_key.kon;
                    ch_params[req.bank][ch_idx].block     <= wr_byte.ch_key.block;
                    ch_params[req.bank][ch_idx].fnum[9:8] <= wr_byte.ch_key.fnum_hi;
                end
                GRP_CH_OUT: begin
                    ch_params[req.bank][ch_idx].chd <= wr_byte.ch_out.chd;
                    ch_params[req.bank][ch_idx].chc <= wr_byte.ch_out.chc;
                    ch_params[req.bank][ch_idx].chb <= wr_byte.ch_out.chb;
                    ch_params[req.bank][ch_idx].cha <= wr_byte.ch_out.cha;
                    ch_params[req.bank][ch_idx].fb  <= wr_byte.ch_out.fb;
                    ch_params[req.bank][ch_idx].cnt <= wr_byte.ch_out.cnt;
                end
                default: ;
            endcase
        end
    end

    // full 5-bit index, upper bit must stay clear for channels
    assert property (@(posedge clk) disable iff (!rst_n)
        ch_write |-> (req.index < NUM_CHANNELS));

endmodule

`default_nettype wire

// File: source/opl3_readback.sv
// read data select, register byte packing, registered data_out and rd_valid
`timescale 1ns/10ps
`default_nettype none

module opl3_readback
    import opl3_reg_map_pkg::*;
    import opl3_voice_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire bus_req_t         req,
    input  wire op_bank_t         op_params,
    input  wire ch_bank_t         ch_params,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  rd_valid
);

    op_params_t op_sel;
    ch_params_t ch_sel;
    reg_byte_u  rd_byte;

    assign op_sel = op_params[req.bank][req.index];
    assign ch_sel = ch_params[req.bank][req.index[3:0]];

    always_comb begin
        rd_byte.raw = '0;  // bits without storage read 0
        case (req.group)
            GRP_OP_CHAR: begin
                rd_byte.op_char.am   = op_sel.am;
                rd_byte.op_char.vib  = op_sel.vib;
                rd_byte.op_char.egt  = op_sel.egt;
                rd_byte.op_char.ksr  = op_sel.ksr;
                rd_byte.op_char.mult = op_sel.mult;
            end
            GRP_OP_LEVEL:   rd_byte.op_level = '{ksl: op_sel.ksl, tl: op_sel.tl};
            GRP_OP_ENV:     rd_byte.op_rate  = '{hi: op_sel.ar, lo: op_sel.dr};
            GRP_OP_SUSTAIN: rd_byte.op_rate  = '{hi: op_sel.sl, lo: op_sel.rr};
            GRP_OP_WAVE:    rd_byte.op_wave.ws = op_sel.ws;
            GRP_CH_FNUM_LO: rd_byte.raw = ch_sel.fnum[7:0];
            GRP_CH_KEY: begin
                rd_byte.ch_key.kon     = ch_sel.kon;
                rd_byte.ch_key.block   = ch_sel.block;
                rd_byte.ch_key.fnum_hi = ch_sel.fnum[9:8];
            end
            GRP_CH_OUT: begin
                rd_byte.ch_out.chd = ch_sel.chd;
                rd_byte.ch_out.chc = ch_sel.chc;
                rd_byte.ch_out.chb = ch_sel.chb;
                rd_byte.ch_out.cha = ch_sel.cha;
                rd_byte.ch_out.fb  = ch_sel.fb;
                rd_byte.ch_out.cnt = ch_sel.cnt;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.rd;  // one pulse per read
            if (req.rd) begin
                data_out <= (req.group == GRP_NONE) ? READ_UNMAPPED : rd_byte.raw;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/opl3_register_file.sv
// register file top, decoder, operator and channel stores, readback
`timescale 1ns/10ps
`default_nettype none

module opl3_register_file
    import opl3_reg_map_pkg::*;
    import opl3_voice_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cs,
    input  wire                   rd,
    input  wire                   wr,
    input  wire                   bank_select,
    input  wire  [ADDR_WIDTH-1:0] address,
    input  wire  [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  rd_valid,
    output op_bank_t              op_params,
    output ch_bank_t              ch_params
);

    bus_req_t req;

    opl3_bus_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .cs          (cs),
        .rd          (rd),
        .wr          (wr),
        .bank_select (bank_select),
        .address     (address),
        .data_in     (data_in),
        .req         (req)
    );

    opl3_operator_regs u_operator_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op_params (op_params)
    );

    opl3_channel_regs u_channel_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ch_params (ch_params)
    );

    // stores update on the same edge, so a read right after a write sees new data
    opl3_readback u_readback (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op_params (op_params),
        .ch_params (ch_params),
        .data_out  (data_out),
        .rd_valid  (rd_valid)
    );

endmodule

`default_nettype wire

// File: sim/tb_opl3_register_file.sv
// testbench: clock, reset, trace file replay, compare tasks, cycle timeout
`timescale 1ns/10ps
`default_nettype none

module tb_opl3_register_file
    import opl3_reg_map_pkg::*;
    import opl3_voice_pkg::*;
();

    localparam string TRACE_FILE = "sim/opl3_reg_trace.txt";

    typedef struct packed {
        logic [7:0]  kind;   // W R O C
        logic [7:0]  bank;
        logic [7:0]  addr;   // bus address, or operator/channel index
        logic [35:0] value;  // write data or expected value
    } trace_rec_t;

    logic                  clk;
    logic                  rst_n;
    logic                  cs;
    logic                  rd;
    logic                  wr;
    logic                  bank_select;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] data_in;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  rd_valid;
    op_bank_t              op_params;
    ch_bank_t              ch_params;

    trace_rec_t trace[$];
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         byte_errors = 0;
    int         op_errors = 0;
    int         ch_errors = 0;
    int         other_errors = 0;
    logic       trace_ok;

    opl3_register_file u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cs          (cs),
        .rd          (rd),
        .wr          (wr),
        .bank_select (bank_select),
        .address     (address),
        .data_in     (data_in),
        .data_out    (data_out),
        .rd_valid    (rd_valid),
        .op_params   (op_params),
        .ch_params   (ch_params)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog, armed once the trace length is known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

    task automatic load_trace(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [7:0]  bank;
        logic [7:0]  addr;
        logic [35:0] value;
        ok = 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%c %h %h %h", kind, bank, addr, value);
                if (n == 4 && kind inside {"W", "R", "O", "C"})  // skips comments, blanks
                    trace.push_back('{kind: kind, bank: bank, addr: addr, value: value});
            end
            $fclose(fd);
        end
    endtask

    task automatic check_byte(input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual,
                              input logic valid, input string what);
        if (!valid) begin
            other_errors++;
            $display("no rd_valid pulse seen for %s", what);
        end else if (actual !== expected) begin
            byte_errors++;
            $display("CHECK FAILED at %0d ns: %s expected %h got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_op(input op_params_t expected, input op_params_t actual,
                            input string what);
        if (actual !== expected) begin
            op_errors++;
            $display("CHECK FAILED at %0d ns: %s expected %h got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_ch(input ch_params_t expected, input ch_params_t actual,
                            input string what);
        if (actual !== expected) begin
            ch_errors++;
            $display("CHECK FAILED at %0d ns: %s expected %h got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic bus_write(input logic bank, input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        cs          <= 1'b1;
        wr          <= 1'b1;
        bank_select <= bank;
        address     <= addr;
        data_in     <= data;
        @(posedge clk);
        cs <= 1'b0;  // idle cycle
        wr <= 1'b0;
    endtask

    task automatic bus_read(input logic bank, input logic [7:0] addr,
                            input logic [7:0] expected);
        logic  seen;
        string what;
        what = $sformatf("read bank %0d address %h", bank, addr);
        @(posedge clk);
        cs          <= 1'b1;
        rd          <= 1'b1;
        bank_select <= bank;
        address     <= addr;
        @(posedge clk);
        cs <= 1'b0;
        rd <= 1'b0;
        seen = 1'b0;
        repeat (3) begin
            if (!seen) begin
                @(negedge clk);
                seen = rd_valid;
            end
        end
        check_byte(expected, data_out, seen, what);
        if (seen) begin
            @(negedge clk);
            if (rd_valid) begin
                other_errors++;
                $display("rd_valid stayed high for more than one cycle on %s", what);
            end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        cs          = 1'b0;
        rd          = 1'b0;
        wr          = 1'b0;
        bank_select = 1'b0;
        address     = '0;
        data_in     = '0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            other_errors++;
            $display("could not open trace file %s", TRACE_FILE);
        end else begin
            cycle_limit = trace.size() * 4 + 20;
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPERATORS; o++)
                    check_op('0, op_params[b][o], $sformatf("reset bank %0d op %0d", b, o));
                for (int c = 0; c < NUM_CHANNELS; c++)
                    check_ch('0, ch_params[b][c], $sformatf("reset bank %0d ch %0d", b, c));
            end
            foreach (trace[i]) begin
                case (trace[i].kind)
                    "W": bus_write(trace[i].bank[0], trace[i].addr, trace[i].value[7:0]);
                    "R": bus_read(trace[i].bank[0], trace[i].addr, trace[i].value[7:0]);
                    "O": begin
                        repeat (3) @(negedge clk);
                        check_op(trace[i].value[35:0],
                                 op_params[trace[i].bank[0]][trace[i].addr[4:0]],
                                 $sformatf("bank %0d operator %0d",
                                           trace[i].bank[0], trace[i].addr));
                    end
                    default: begin
                        repeat (3) @(negedge clk);
                        check_ch(trace[i].value[21:0],
                                 ch_params[trace[i].bank[0]][trace[i].addr[3:0]],
                                 $sformatf("bank %0d channel %0d",
                                           trace[i].bank[0], trace[i].addr));
                    end
                endcase
            end
        end
        $display("errors: read data %0d, operator %0d, channel %0d, other %0d",
                 byte_errors, op_errors, ch_errors, other_errors);
        if (byte_errors + op_errors + ch_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/opl3_reg_trace.txt
# kind bank address value: W writes value, R expects the read byte
# O bank operator op_params_t, C bank channel ch_params_t; all fields hex
R 0 20 00
W 0 20 e1
W 0 40 8a
W 0 60 f3
W 0 80 27
W 0 e0 fd
W 0 28 1f
W 0 e8 02
W 0 55 3f
W 0 95 c4
W 0 f5 06
O 0 00 70c57993d
O 0 06 0f8000002
O 0 11 001f80626
R 0 f5 06
R 0 95 c4
W 1 20 55
R 1 20 55
R 0 20 e1
O 1 00 2a8000000
W 0 a3 5c
W 0 b3 f6
W 0 c3 a9
C 0 03 25cb59
R 0 b3 36
R 0 c3 a9
R 0 a3 5c
W 0 e0 ff
R 0 e0 07
W 0 26 ff
W 0 a9 ff
W 1 04 ff
W 0 bd ff
R 0 26 ff
R 0 a9 ff
R 1 04 ff
R 0 bd ff
O 0 00 70c57993f
O 1 00 2a8000000
C 0 03 25cb59
C 1 03 000000

// File: all.f
source/opl3_reg_map_pkg.sv
source/opl3_voice_pkg.sv
source/opl3_bus_decoder.sv
source/opl3_operator_regs.sv
source/opl3_channel_regs.sv
source/opl3_readback.sv
source/opl3_register_file.sv
sim/tb_opl3_register_file.sv

// File: Bender.yml
package:
  name: opl3_register_file

sources:
  - source/opl3_reg_map_pkg.sv
  - source/opl3_voice_pkg.sv
  - source/opl3_bus_decoder.sv
  - source/opl3_operator_regs.sv
  - source/opl3_channel_regs.sv
  - source/opl3_readback.sv
  - source/opl3_register_file.sv
  - target: test
    files:
      - sim/tb_opl3_register_file.sv
